/* logic/bpred_pkg.sv */
package bpred_pkg;

  // ==============================
  // table sizes.
  // ==============================
  localparam int lht_depth   = 16;
  localparam int lhist_bits  = 4;
  localparam int ghist_bits  = 4;
  localparam int queue_depth = 4;

  typedef logic [31:0]                    pc_t;
  typedef logic [$clog2(lht_depth)-1:0]   lht_idx_t;
  typedef logic [lhist_bits-1:0]          lhist_t;
  typedef logic [ghist_bits-1:0]          ghist_t;
  // upper bit means taken, or use global in the chooser.
  typedef logic [1:0]                     ctr_t;

  // snapshot of one prediction, kept until it resolves.
  typedef struct packed {
    lht_idx_t lht_idx;
    lhist_t   lhist;
    ghist_t   ghist;
    logic     local_guess;
    logic     global_guess;
  } inflight_rec_t;

  // ==============================
  // helpers.
  // ==============================
  // instructions are two-byte aligned, so bit 0 carries nothing.
  function automatic lht_idx_t lht_index(pc_t pc);
    return pc[$clog2(lht_depth):1];
  endfunction

  function automatic ctr_t ctr_inc(ctr_t c);
    return (c == 2'b11) ? c : c + 2'b01;
  endfunction

  function automatic ctr_t ctr_dec(ctr_t c);
    return (c == 2'b00) ? c : c - 2'b01;
  endfunction

  function automatic ctr_t ctr_train(ctr_t c, logic up);
    return up ? ctr_inc(c) : ctr_dec(c);
  endfunction

endpackage

/* logic/local_predictor.sv */
module local_predictor (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  bpred_pkg::lht_idx_t      lookup_idx,
  output bpred_pkg::lhist_t        lhist_out,
  output logic                     guess_out,
  input  logic                     train_in,
  input  bpred_pkg::inflight_rec_t train_rec,
  input  logic                     train_taken
);
  import bpred_pkg::*;

  // per-pc history, then counters indexed by that history.
  lhist_t lht [lht_depth];
  ctr_t   lct [2**lhist_bits];

  lhist_t train_hist;

  // ==============================
  // lookup.
  // ==============================
  always_comb begin
    lhist_out = lht[lookup_idx];
    guess_out = lct[lhist_out][1];
  end

  // the entry may have moved since predict time; shift what is there now.
  assign train_hist = lht[train_rec.lht_idx];

  // ==============================
  // training.
  // ==============================
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < lht_depth; i++) begin
        lht[i] <= '0;
      end
      for (int i = 0; i < 2**lhist_bits; i++) begin
        lct[i] <= '0;
      end
    end else if (train_in) begin
      lht[train_rec.lht_idx] <= {train_hist[lhist_bits-2:0], train_taken};
      // counter at the history seen when the guess was made.
      lct[train_rec.lhist]   <= ctr_train(lct[train_rec.lhist], train_taken);
    end
  end

endmodule

/* logic/global_predictor.sv */
module global_predictor (
  input  logic                     clk_in,
  input  logic                     rst_in,
  output bpred_pkg::ghist_t        ghist_out,
  output logic                     guess_out,
  input  logic                     train_in,
  input  bpred_pkg::inflight_rec_t train_rec,
  input  logic                     train_taken
);
  import bpred_pkg::*;

  ghist_t ghist_q;
  ctr_t   gct [2**ghist_bits];

  assign ghist_out = ghist_q;
  assign guess_out = gct[ghist_q][1];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ghist_q <= '0;
      for (int i = 0; i < 2**ghist_bits; i++) begin
        gct[i] <= '0;
      end
    end else if (train_in) begin
      // resolved path history, in program order.
      ghist_q              <= {ghist_q[ghist_bits-2:0], train_taken};
      gct[train_rec.ghist] <= ctr_train(gct[train_rec.ghist], train_taken);
    end
  end

  // exactly one outcome bit enters per train, none otherwise.
  a_ghist_step: assert property (
    @(posedge clk_in) disable iff (rst_in)
    ##1 ghist_q == ($past(train_in) ?
                    {$past(ghist_q[ghist_bits-2:0]), $past(train_taken)} :
                    $past(ghist_q))
  ) else $error("global history moved by other than one bit per train");

endmodule

/* logic/choice_predictor.sv */
module choice_predictor (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  bpred_pkg::ghist_t        ghist_in,
  output logic                     use_global_out,
  input  logic                     train_in,
  input  bpred_pkg::inflight_rec_t train_rec,
  input  logic                     train_taken
);
  import bpred_pkg::*;

  ctr_t cct [2**ghist_bits];

  logic disagree;
  logic global_right;

  assign use_global_out = cct[ghist_in][1];

  // agreement says nothing about which component is better.
  assign disagree     = train_rec.local_guess != train_rec.global_guess;
  assign global_right = train_rec.global_guess == train_taken;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < 2**ghist_bits; i++) begin
        cct[i] <= '0;
      end
    end else if (train_in && disagree) begin
      cct[train_rec.ghist] <= ctr_train(cct[train_rec.ghist], global_right);
    end
  end

endmodule

/* logic/inflight_queue.sv */
module inflight_queue (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic                     push_in,
  input  bpred_pkg::inflight_rec_t push_rec,
  input  logic                     pop_in,
  output bpred_pkg::inflight_rec_t head_rec,
  output logic                     pop_ok_out,
  output logic                     overflow_out,
  output logic                     underflow_out
);
  import bpred_pkg::*;

  inflight_rec_t mem [queue_depth];

  logic [$clog2(queue_depth)-1:0] wr_ptr;
  logic [$clog2(queue_depth)-1:0] rd_ptr;
  logic [$clog2(queue_depth+1)-1:0] count;

  logic full;
  logic empty;
  logic push_ok;

  assign full  = count == queue_depth;
  assign empty = count == '0;

  // a full queue drops the push even if a pop frees a slot this cycle.
  assign push_ok    = push_in && !full;
  assign pop_ok_out = pop_in && !empty;
  assign head_rec   = mem[rd_ptr];

  // ==============================
  // pointers and count.
  // ==============================
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      overflow_out  <= 1'b0;
      underflow_out <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == queue_depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok_out) begin
        rd_ptr <= (rd_ptr == queue_depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push_ok && !pop_ok_out) begin
        count <= count + 1'b1;
      end else if (pop_ok_out && !push_ok) begin
        count <= count - 1'b1;
      end
      overflow_out  <= push_in && full;
      underflow_out <= pop_in && empty;
    end
  end

  // record storage.
  always_ff @(posedge clk_in) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_rec;
    end
  end

  a_count_bound: assert property (
    @(posedge clk_in) disable iff (rst_in)
    count <= queue_depth
  ) else $error("in-flight count above queue depth");

  a_flow_excl: assert property (
    @(posedge clk_in) disable iff (rst_in)
    !(overflow_out && underflow_out)
  ) else $error("overflow and underflow in the same cycle");

endmodule

/* logic/branch_unit.sv */
module branch_unit (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           predict_valid_in,
  input  bpred_pkg::pc_t pc_in,
  output logic           pred_valid_out,
  output logic           pred_taken_out,
  input  logic           resolve_valid_in,
  input  logic           resolve_taken_in,
  output logic           overflow_out,
  output logic           underflow_out
);
  import bpred_pkg::*;

  logic     req_valid;
  pc_t      req_pc;
  lht_idx_t req_idx;

  lhist_t   local_hist;
  ghist_t   global_hist;
  logic     local_guess;
  logic     global_guess;
  logic     use_global;
  logic     final_guess;

  inflight_rec_t push_rec;
  inflight_rec_t head_rec;
  logic          train;

  // ==============================
  // request register.
  // ==============================
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= predict_valid_in;
    end
  end

  always_ff @(posedge clk_in) begin
    req_pc <= pc_in;
  end

  assign req_idx     = lht_index(req_pc);
  assign final_guess = use_global ? global_guess : local_guess;

  assign push_rec = '{lht_idx:      req_idx,
                      lhist:        local_hist,
                      ghist:        global_hist,
                      local_guess:  local_guess,
                      global_guess: global_guess};

  // ==============================
  // response register.
  // ==============================
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pred_valid_out <= 1'b0;
      pred_taken_out <= 1'b0;
    end else begin
      pred_valid_out <= req_valid;
      if (req_valid) begin
        pred_taken_out <= final_guess;
      end
    end
  end

  local_predictor u_local (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .lookup_idx  (req_idx),
    .lhist_out   (local_hist),
    .guess_out   (local_guess),
    .train_in    (train),
    .train_rec   (head_rec),
    .train_taken (resolve_taken_in)
  );

  global_predictor u_global (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .ghist_out   (global_hist),
    .guess_out   (global_guess),
    .train_in    (train),
    .train_rec   (head_rec),
    .train_taken (resolve_taken_in)
  );

  choice_predictor u_choice (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .ghist_in       (global_hist),
    .use_global_out (use_global),
    .train_in       (train),
    .train_rec      (head_rec),
    .train_taken    (resolve_taken_in)
  );

  // resolves arrive in order, so the head is always the one resolving.
  inflight_queue u_queue (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .push_in       (req_valid),
    .push_rec      (push_rec),
    .pop_in        (resolve_valid_in),
    .head_rec      (head_rec),
    .pop_ok_out    (train),
    .overflow_out  (overflow_out),
    .underflow_out (underflow_out)
  );

endmodule

/* sim/predictor_model.sv */
module predictor_model (
  input  logic           clk_in,
  input  logic           rst_in,
  input  logic           predict_valid,
  input  bpred_pkg::pc_t pc,
  input  logic           resolve_valid,
  input  logic           resolve_taken,
  output logic           pred_valid,
  output logic           pred_taken,
  output logic           overflow,
  output logic           underflow
);
  timeunit 1ns;
  timeprecision 100ps;
  import bpred_pkg::*;

  lhist_t        lht [lht_depth];
  ctr_t          lct [2**lhist_bits];
  ctr_t          gct [2**ghist_bits];
  ctr_t          cct [2**ghist_bits];
  ghist_t        ghist;
  inflight_rec_t pending [$];
  logic          req_valid;
  pc_t           req_pc;

  // two-bit saturating step toward the outcome.
  function automatic ctr_t sat_step(ctr_t c, logic up);
    if (up) begin
      return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  always @(posedge clk_in) begin
    inflight_rec_t fresh;
    inflight_rec_t done;
    logic          full_now;
    logic          empty_now;
    if (rst_in) begin
      foreach (lht[i]) lht[i] = '0;
      foreach (lct[i]) lct[i] = '0;
      foreach (gct[i]) gct[i] = '0;
      foreach (cct[i]) cct[i] = '0;
      ghist = '0;
      pending.delete();
      req_valid = 1'b0;
      req_pc = '0;
      pred_valid <= 1'b0;
      pred_taken <= 1'b0;
      overflow   <= 1'b0;
      underflow  <= 1'b0;
    end else begin
      full_now  = pending.size() == queue_depth;
      empty_now = pending.size() == 0;
      // lookup sees the tables as they were before this edge.
      fresh.lht_idx      = req_pc[$clog2(lht_depth):1];
      fresh.lhist        = lht[fresh.lht_idx];
      fresh.ghist        = ghist;
      fresh.local_guess  = lct[fresh.lhist][1];
      fresh.global_guess = gct[ghist][1];
      pred_valid <= req_valid;
      if (req_valid) begin
        pred_taken <= cct[ghist][1] ? fresh.global_guess : fresh.local_guess;
      end
      overflow  <= req_valid && full_now;
      underflow <= resolve_valid && empty_now;

      if (resolve_valid && !empty_now) begin
        done = pending.pop_front();
        lht[done.lht_idx] = {lht[done.lht_idx][lhist_bits-2:0], resolve_taken};
        lct[done.lhist]   = sat_step(lct[done.lhist], resolve_taken);
        gct[done.ghist]   = sat_step(gct[done.ghist], resolve_taken);
        ghist             = {ghist[ghist_bits-2:0], resolve_taken};
        if (done.local_guess != done.global_guess) begin
          cct[done.ghist] = sat_step(cct[done.ghist], done.global_guess == resolve_taken);
        end
      end
      if (req_valid && !full_now) begin
        pending.push_back(fresh);
      end
      req_valid = predict_valid;
      req_pc    = pc;
    end
  end

endmodule

/* sim/branch_unit_tb.sv */
module branch_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import bpred_pkg::*;

  localparam int resp_timeout = 20;

  logic clk_in;
  logic rst_in;
  logic predict_valid_in;
  pc_t  pc_in;
  logic resolve_valid_in;
  logic resolve_taken_in;
  logic pred_valid_out;
  logic pred_taken_out;
  logic overflow_out;
  logic underflow_out;

  logic model_valid;
  logic model_taken;
  logic model_overflow;
  logic model_underflow;

  logic [31:0] rand_state;
  int          errors;
  int          tests_passed;
  int          tests_failed;

  branch_unit UUT (.*);

  predictor_model ref_model (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .predict_valid (predict_valid_in),
    .pc            (pc_in),
    .resolve_valid (resolve_valid_in),
    .resolve_taken (resolve_taken_in),
    .pred_valid    (model_valid),
    .pred_taken    (model_taken),
    .overflow      (model_overflow),
    .underflow     (model_underflow)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // ==============================
  // checks against the model.
  // ==============================
  a_model_match: assert property (
    @(posedge clk_in) disable iff (rst_in)
    {pred_valid_out, pred_taken_out, overflow_out, underflow_out} ==
    {model_valid, model_taken, model_overflow, model_underflow}
  ) else begin
    $display("mismatch at %0t ns: dut vld/tkn/ovf/unf %b%b%b%b, model %b%b%b%b", $time,
             $sampled(pred_valid_out), $sampled(pred_taken_out),
             $sampled(overflow_out), $sampled(underflow_out),
             $sampled(model_valid), $sampled(model_taken),
             $sampled(model_overflow), $sampled(model_underflow));
    errors++;
  end

  // response lands one cycle after the request register.
  a_resp_latency: assert property (
    @(posedge clk_in) disable iff (rst_in)
    pred_valid_out == $past(predict_valid_in, 2)
  ) else begin
    $display("mismatch at %0t ns: pred_valid_out not one cycle after request", $time);
    errors++;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic tick();
    @(posedge clk_in);
    #5;
  endtask

  task automatic request(input pc_t pc, output logic taken, output logic ovf);
    int waited;
    predict_valid_in = 1'b1;
    pc_in = pc;
    tick();
    predict_valid_in = 1'b0;
    tick();
    waited = 1;
    while (!pred_valid_out && waited < resp_timeout) begin
      tick();
      waited++;
    end
    if (!pred_valid_out) begin
      $display("timeout: no prediction response for pc %h", pc);
      errors++;
    end
    taken = pred_taken_out;
    ovf = overflow_out;
  endtask

  task automatic resolve(input logic taken, output logic unf);
    resolve_valid_in = 1'b1;
    resolve_taken_in = taken;
    tick();
    resolve_valid_in = 1'b0;
    unf = underflow_out;
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    logic taken;
    logic ovf;
    logic unf;
    int   e0;
    int   first_taken;
    int   correct;
    int   preds;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    rand_state = 32'hb422;
    rst_in = 1'b1;
    predict_valid_in = 1'b0;
    pc_in = '0;
    resolve_valid_in = 1'b0;
    resolve_taken_in = 1'b0;
    repeat (4) @(posedge clk_in);
    #5 rst_in = 1'b0;

    // ==============================
    // directed tests.
    // ==============================
    e0 = errors;
    for (int i = 0; i < 2; i++) begin
      request(32'h1000 + i * 4, taken, ovf);
      assert (!taken) else begin
        $display("mismatch at %0t ns: prediction after reset is taken", $time);
        errors++;
      end
    end
    resolve(1'b0, unf);
    resolve(1'b0, unf);
    close_test("reset_response", e0);

    e0 = errors;
    first_taken = -1;
    for (int i = 0; i < 10; i++) begin
      request(32'h2006, taken, ovf);
      if (taken && first_taken < 0) first_taken = i;
      resolve(1'b1, unf);
    end
    assert (first_taken >= 0 && taken) else begin
      $display("mismatch at %0t ns: always-taken branch never predicted taken", $time);
      errors++;
    end
    close_test("always_taken", e0);

    // alternating outcome, starting taken.
    e0 = errors;
    correct = 0;
    for (int i = 0; i < 24; i++) begin
      request(32'h300a, taken, ovf);
      if (i >= 16 && taken == (i % 2 == 0)) correct++;
      resolve(i % 2 == 0, unf);
    end
    assert (correct == 8) else begin
      $display("mismatch at %0t ns: alternating branch right %0d of 8 times", $time, correct);
      errors++;
    end
    close_test("alternating", e0);

    e0 = errors;
    for (int i = 0; i < 5; i++) begin
      request(32'h5000, taken, ovf);
      assert (ovf == (i == 4)) else begin
        $display("mismatch at %0t ns: overflow_out %b on request %0d", $time, ovf, i);
        errors++;
      end
    end
    for (int i = 0; i < 5; i++) begin
      resolve(1'b1, unf);
      assert (unf == (i == 4)) else begin
        $display("mismatch at %0t ns: underflow_out %b on resolve %0d", $time, unf, i);
        errors++;
      end
    end
    close_test("overflow_underflow", e0);

    // ==============================
    // random interleaving.
    // ==============================
    e0 = errors;
    preds = 0;
    for (int c = 0; c < 300; c++) begin
      rand_state = next_rand(rand_state);
      predict_valid_in = rand_state[16];
      pc_in = {27'h200, rand_state[20:17], 1'b0};
      resolve_valid_in = rand_state[24];
      resolve_taken_in = rand_state[25] ^ rand_state[18];
      tick();
      if (pred_valid_out) preds++;
    end
    predict_valid_in = 1'b0;
    resolve_valid_in = 1'b0;
    tick();
    tick();
    assert (preds > 50) else begin
      $display("random phase produced only %0d predictions", preds);
      errors++;
    end
    close_test("random", e0);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/bpred_pkg.sv
logic/local_predictor.sv
logic/global_predictor.sv
logic/choice_predictor.sv
logic/inflight_queue.sv
logic/branch_unit.sv
sim/predictor_model.sv
sim/branch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module branch_unit_tb -f vlog.f -Mdir obj_dir -o branch_unit_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/branch_unit_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
